//--- all.f
logic/hazard_pkg.sv
logic/instr_classifier.sv
logic/stage_tracker.sv
logic/hazard_control_unit.sv
logic/hazard_top.sv
verification/hazard_tb.sv

//--- logic/hazard_control_unit.sv
// Hazard control for the five-stage pipeline. From the ID, EX and MM
// summaries and the cache hit flags it picks the next pc source and
// drives the pipeline register enables and flushes, all combinationally.
`default_nettype none
`timescale 1ns/1ps

module hazard_control_unit import hazard_pkg::*; (
  input  stage_info_t  id_info,
  input  stage_info_t  ex_info,
  input  stage_info_t  mm_info,
  input  logic         ihit,
  input  logic         dhit,
  input  logic         mm_equal,
  output pc_select_t   pc_select,
  output hazard_ctrl_t ctrl
);

  logic id_reads_rs;
  logic id_reads_rt;
  logic rs_match;
  logic rt_match;
  logic mem_wait;
  logic load_use;
  logic br_taken;
  logic jr_in_ex;
  logic jump_in_ex;

  // which source registers the instruction in ID actually reads
  assign id_reads_rs = (id_info.opfunc == OTHERR) || (id_info.opfunc == OBEQ) ||
                       (id_info.opfunc == OBNE)   || (id_info.opfunc == OJR)  ||
                       (id_info.opfunc == OSL)    || (id_info.opfunc == OLW)  ||
                       (id_info.opfunc == OSW)    || (id_info.opfunc == OTHERI);
  assign id_reads_rt = (id_info.opfunc == OTHERR) || (id_info.opfunc == OBEQ) ||
                       (id_info.opfunc == OBNE);

  // a load writes its rt
  assign rs_match = id_reads_rs && (id_info.rs == ex_info.rt);
  assign rt_match = id_reads_rt && (id_info.rt == ex_info.rt);

  assign mem_wait = (mm_info.opfunc == OLW) || (mm_info.opfunc == OSW);
  assign load_use = (ex_info.opfunc == OLW) && (rs_match || rt_match);
  assign br_taken = ((mm_info.opfunc == OBEQ) && mm_equal) ||
                    ((mm_info.opfunc == OBNE) && !mm_equal);

  // a taken branch in MM is older, so it squashes any jump behind it
  assign jr_in_ex   = (ex_info.opfunc == OJR) && !br_taken;
  assign jump_in_ex = ((ex_info.opfunc == OJ) || (ex_info.opfunc == OJAL)) && !br_taken;

  always_comb begin
    pc_select       = PCNPC;
    ctrl.pc_en      = ihit;  // advance only when a word was fetched
    ctrl.ifid_en    = ihit;
    ctrl.idex_en    = ihit;
    ctrl.exmm_en    = ihit;
    ctrl.mmwb_en    = ihit;
    ctrl.ifid_flush = 1'b0;
    ctrl.idex_flush = 1'b0;
    ctrl.exmm_flush = 1'b0;

    if (mem_wait) begin
      ctrl.pc_en      = ihit && dhit;
      ctrl.ifid_en    = dhit;
      ctrl.idex_en    = dhit;
      ctrl.exmm_en    = dhit;
      ctrl.mmwb_en    = dhit;
      // data is back but the fetch missed, so IF/ID gets a bubble
      ctrl.ifid_flush = !ihit && dhit;
    end

    if (load_use) begin
      ctrl.pc_en      = 1'b0;
      ctrl.ifid_en    = 1'b0;
      ctrl.idex_flush = 1'b1;  // bubble into EX while ID waits a cycle
    end

    if (br_taken) begin
      pc_select       = PCBPC;
      ctrl.ifid_flush = 1'b1;
      ctrl.idex_flush = 1'b1;
      ctrl.exmm_flush = 1'b1;
    end

    if (jr_in_ex) begin
      pc_select       = PCPTA;
      ctrl.ifid_flush = 1'b1;
      ctrl.idex_flush = 1'b1;
    end

    if (jump_in_ex) begin
      pc_select       = PCJPC;
      ctrl.ifid_flush = 1'b1;
      ctrl.idex_flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/hazard_pkg.sv
// Shared types and constants for the pipeline hazard control subsystem.
// Import with a wildcard in the module header of any block that decodes
// instructions, tracks stage summaries or drives the pipeline controls.
`default_nettype none

package hazard_pkg;

  // instruction field widths
  localparam int OP_W  = 6;
  localparam int REG_W = 5;
  localparam int IMM_W = 16;

  // primary opcodes
  localparam logic [OP_W-1:0] OP_RTYPE = 6'b000000;
  localparam logic [OP_W-1:0] OP_J     = 6'b000010;
  localparam logic [OP_W-1:0] OP_JAL   = 6'b000011;
  localparam logic [OP_W-1:0] OP_BEQ   = 6'b000100;
  localparam logic [OP_W-1:0] OP_BNE   = 6'b000101;
  localparam logic [OP_W-1:0] OP_LW    = 6'b100011;
  localparam logic [OP_W-1:0] OP_SW    = 6'b101011;

  // function codes of interest within the R-type opcode
  localparam logic [OP_W-1:0] FN_SLL = 6'b000000;
  localparam logic [OP_W-1:0] FN_SRL = 6'b000010;
  localparam logic [OP_W-1:0] FN_JR  = 6'b001000;

  // coarse instruction class, all the hazard logic needs to know
  typedef enum logic [3:0] {
    ONOP   = 4'd0,
    OTHERR = 4'd1,
    OSL    = 4'd2,  // sll and srl
    OJR    = 4'd3,
    OBEQ   = 4'd4,
    OBNE   = 4'd5,
    OLW    = 4'd6,
    OSW    = 4'd7,
    OTHERI = 4'd8,
    OJ     = 4'd9,
    OJAL   = 4'd10
  } opfunc_t;

  typedef struct packed {
    logic [OP_W-1:0]  opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] shamt;
    logic [OP_W-1:0]  funct;
  } r_fields_t;

  typedef struct packed {
    logic [OP_W-1:0]  opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [IMM_W-1:0] imm;
  } i_fields_t;

  // one instruction word, seen as R-type or as I/J-type
  typedef union packed {
    r_fields_t r_view;
    i_fields_t i_view;
  } instr_u;

  // per-stage summary carried down the pipeline
  typedef struct packed {
    opfunc_t          opfunc;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
  } stage_info_t;

  typedef enum logic [1:0] {
    PCNPC = 2'd0,  // next sequential pc
    PCBPC = 2'd1,  // branch target computed in mm
    PCPTA = 2'd2,  // register target from ex
    PCJPC = 2'd3   // jump target from ex
  } pc_select_t;

  typedef struct packed {
    logic pc_en;
    logic ifid_en;
    logic idex_en;
    logic exmm_en;
    logic mmwb_en;
    logic ifid_flush;
    logic idex_flush;
    logic exmm_flush;
  } hazard_ctrl_t;

  localparam instr_u      NOP_WORD = '0;
  localparam stage_info_t NOP_INFO = '{opfunc: ONOP, rs: '0, rt: '0};

endpackage

`default_nettype wire

//--- logic/hazard_top.sv
// Top level of the hazard control subsystem. The classifier decodes the
// IF/ID word, the tracker carries summaries to EX and MM, and the hazard
// unit closes the loop by driving the tracker's enables and flushes.
`default_nettype none
`timescale 1ns/1ps

module hazard_top import hazard_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  input  instr_u       instr,
  input  logic         ihit,
  input  logic         dhit,
  input  logic         mm_equal,
  output pc_select_t   pc_select,
  output hazard_ctrl_t ctrl
);

  instr_u      ifid_word;
  stage_info_t id_info;
  stage_info_t ex_info;
  stage_info_t mm_info;

  instr_classifier u_instr_classifier (
    .word (ifid_word),
    .info (id_info)
  );

  stage_tracker u_stage_tracker (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr     (instr),
    .ihit      (ihit),
    .id_info   (id_info),
    .ctrl      (ctrl),  // fed back from the hazard unit
    .ifid_word (ifid_word),
    .ex_info   (ex_info),
    .mm_info   (mm_info)
  );

  hazard_control_unit u_hazard_control_unit (
    .id_info   (id_info),
    .ex_info   (ex_info),
    .mm_info   (mm_info),
    .ihit      (ihit),
    .dhit      (dhit),
    .mm_equal  (mm_equal),
    .pc_select (pc_select),
    .ctrl      (ctrl)
  );

endmodule

`default_nettype wire

//--- logic/instr_classifier.sv
// Decodes the instruction word held in IF/ID into the stage summary used
// by the hazard logic: instruction class plus the rs and rt fields.
// Purely combinational.
`default_nettype none
`timescale 1ns/1ps

module instr_classifier import hazard_pkg::*; (
  input  instr_u      word,
  output stage_info_t info
);

  logic    is_rtype;
  logic    is_jump;
  opfunc_t r_class;
  opfunc_t op_class;

  assign is_rtype = (word.i_view.opcode == OP_RTYPE);

  // R-type words split on funct
  always_comb begin
    case (word.r_view.funct)
      FN_JR:   r_class = OJR;
      FN_SLL:  r_class = OSL;
      FN_SRL:  r_class = OSL;
      default: r_class = OTHERR;
    endcase
  end

  // everything else splits on the primary opcode
  always_comb begin
    case (word.i_view.opcode)
      OP_J:    op_class = OJ;
      OP_JAL:  op_class = OJAL;
      OP_BEQ:  op_class = OBEQ;
      OP_BNE:  op_class = OBNE;
      OP_LW:   op_class = OLW;
      OP_SW:   op_class = OSW;
      default: op_class = OTHERI;
    endcase
  end

  assign is_jump = (op_class == OJ) || (op_class == OJAL);

  always_comb begin
    info = NOP_INFO;  // the all-zero word stays a bubble
    if (word != NOP_WORD) begin
      info.opfunc = is_rtype ? r_class : op_class;
      if (!is_jump) begin  // J-type carries a target, not registers
        info.rs = word.i_view.rs;  // rs and rt sit at the same bits in both views
        info.rt = word.i_view.rt;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/stage_tracker.sv
// Pipeline registers for hazard tracking: the raw IF/ID word and the
// ID/EX and EX/MM summaries. Each slot obeys its flush first, then its
// enable, and otherwise holds. Slots reset to a bubble.
`default_nettype none
`timescale 1ns/1ps

module stage_tracker import hazard_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  input  instr_u       instr,
  input  logic         ihit,
  input  stage_info_t  id_info,
  input  hazard_ctrl_t ctrl,
  output instr_u       ifid_word,
  output stage_info_t  ex_info,
  output stage_info_t  mm_info
);

  instr_u      ifid_next;
  stage_info_t idex_next;
  stage_info_t exmm_next;

  // next value of a summary slot, flush wins over enable
  function automatic stage_info_t info_next(
    input logic        flush,
    input logic        en,
    input stage_info_t cur,
    input stage_info_t prev
  );
    stage_info_t nxt;
    nxt = cur;
    if (flush) begin
      nxt = NOP_INFO;
    end else if (en) begin
      nxt = prev;
    end
    return nxt;
  endfunction

  always_comb begin
    ifid_next = ifid_word;
    if (ctrl.ifid_flush) begin
      ifid_next = NOP_WORD;
    end else if (ctrl.ifid_en) begin
      ifid_next = ihit ? instr : NOP_WORD;  // a missed fetch becomes a bubble
    end
  end

  assign idex_next = info_next(ctrl.idex_flush, ctrl.idex_en, ex_info, id_info);
  assign exmm_next = info_next(ctrl.exmm_flush, ctrl.exmm_en, mm_info, ex_info);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ifid_word <= NOP_WORD;
      ex_info   <= NOP_INFO;
      mm_info   <= NOP_INFO;
    end else begin
      ifid_word <= ifid_next;
      ex_info   <= idex_next;
      mm_info   <= exmm_next;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the hazard control testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
  -f all.f \
  --top-module hazard_tb \
  --Mdir obj_dir \
  -o hazard_sim

./obj_dir/hazard_sim | tee "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

//--- verification/hazard_golden.txt
// columns: test instr(hex) ihit dhit mm_equal pc_select(0 npc,1 bpc,2 pta,3 jpc)
// ctrl bits: pc_en ifid_en idex_en exmm_en mmwb_en ifid_flush idex_flush exmm_flush
// test 1: idle after reset
1 00000000 1 0 0 0 11111000
1 00000000 0 0 0 0 00000000
1 00000000 0 1 1 0 00000000
1 00000000 1 1 0 0 11111000
// test 2: lw $2 then add $3,$2,$4
2 8C220000 1 1 0 0 11111000
2 00441820 1 1 0 0 11111000
2 00C72820 1 1 0 0 00111010
2 00C72820 1 1 0 0 11111000
2 00000000 1 1 0 0 11111000
// test 3: sw waits in MM, dhit with ihit low, then lw waits, dhit with ihit high
3 AC220004 1 0 0 0 11111000
3 00C72820 1 0 0 0 11111000
3 00000000 1 0 0 0 11111000
3 21280001 1 0 0 0 00000000
3 21280001 1 0 0 0 00000000
3 21280001 0 1 0 0 01111100
3 8C220000 1 0 0 0 11111000
3 00000000 1 0 0 0 11111000
3 00000000 1 0 0 0 11111000
3 21280001 1 0 0 0 00000000
3 21280001 1 1 0 0 11111000
3 00000000 1 0 0 0 11111000
// test 4: beq taken in MM, then bne not taken
4 10220003 1 1 0 0 11111000
4 00C72820 1 1 0 0 11111000
4 21280001 1 1 0 0 11111000
4 00441820 1 1 1 1 11111111
4 14220003 1 1 1 0 11111000
4 00000000 1 1 1 0 11111000
4 00000000 1 1 1 0 11111000
4 00C72820 1 1 1 0 11111000
4 00000000 1 1 0 0 11111000
// test 5: jr, j and jal in EX, then taken branches in MM over j and jr
5 03E00008 1 1 0 0 11111000
5 00C72820 1 1 0 0 11111000
5 21280001 1 1 0 2 11111110
5 08000010 1 1 0 0 11111000
5 21280001 1 1 0 0 11111000
5 00C72820 1 1 0 3 11111110
5 0C000010 1 1 0 0 11111000
5 00000000 1 1 0 0 11111000
5 21280001 1 1 0 3 11111110
5 10220003 1 1 0 0 11111000
5 08000010 1 1 0 0 11111000
5 21280001 1 1 0 0 11111000
5 00C72820 1 1 1 1 11111111
5 14220003 1 1 1 0 11111000
5 03E00008 1 1 1 0 11111000
5 21280001 1 1 1 0 11111000
5 00C72820 1 1 0 1 11111111
// test 6: add after lw misses the fetch and becomes a bubble, no stall later
6 AC220004 1 1 0 0 11111000
6 21280001 1 1 0 0 11111000
6 8C220000 1 0 0 0 11111000
6 00441820 0 0 0 0 00000000
6 00441820 0 1 0 0 01111100
6 00441820 1 1 0 0 11111000
6 00000000 1 1 0 0 11111000
6 00000000 1 1 0 0 11111000

//--- verification/hazard_tb.sv
// Testbench for the hazard control subsystem. Replays the per-cycle vectors
// of the golden file against the top level and compares pc_select and ctrl
// one step before each rising edge. Run from the project root.
`default_nettype none
`timescale 1ns/1ps

module hazard_tb import hazard_pkg::*; ();

  localparam int    CLK_PERIOD  = 10;
  localparam string GOLDEN_FILE = "verification/hazard_golden.txt";

  // one golden line, inputs followed by the expected outputs
  typedef struct packed {
    logic [7:0]   test_id;
    instr_u       instr;
    logic         ihit;
    logic         dhit;
    logic         mm_equal;
    pc_select_t   exp_pc;
    hazard_ctrl_t exp_ctrl;
  } golden_vec_t;

  logic         clk = 1'b0;
  logic         arst_n;
  instr_u       instr;
  logic         ihit;
  logic         dhit;
  logic         mm_equal;
  pc_select_t   pc_select;
  hazard_ctrl_t ctrl;

  golden_vec_t vectors[$];
  int          num_vectors;
  bit          vectors_loaded = 1'b0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  hazard_top u_hazard_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr     (instr),
    .ihit      (ihit),
    .dhit      (dhit),
    .mm_equal  (mm_equal),
    .pc_select (pc_select),
    .ctrl      (ctrl)
  );

  function automatic string test_title(input logic [7:0] test_id);
    case (test_id)
      8'd1:    return "idle after reset";
      8'd2:    return "load-use stall";
      8'd3:    return "data memory wait";
      8'd4:    return "branch resolved in MM";
      8'd5:    return "jumps resolved in EX";
      8'd6:    return "missed fetch bubble";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_pc_select(input pc_select_t got, input pc_select_t exp, input int vec_no);
    if (got !== exp) begin
      $display("Fail at %0t: vector %0d pc_select is %s, expected %s",
               $time, vec_no, got.name(), exp.name());
      test_errors++;
    end
  endtask

  task automatic check_ctrl(input hazard_ctrl_t got, input hazard_ctrl_t exp, input int vec_no);
    if (got !== exp) begin
      $display("Fail at %0t: vector %0d ctrl is %b, expected %b", $time, vec_no, got, exp);
      test_errors++;
    end
  endtask

  task automatic report_test(input logic [7:0] test_id, input int cycles);
    if (test_errors == 0) begin
      $display("Test %0d (%s): passed over %0d cycles", test_id, test_title(test_id), cycles);
      tests_passed++;
    end else begin
      $display("Test %0d (%s): %0d mismatches over %0d cycles",
               test_id, test_title(test_id), test_errors, cycles);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // comment lines start with // and blank lines are skipped
  task automatic load_golden(output bit ok);
    int          fd;
    int          fields;
    int          line_no;
    int          test_id;
    string       line;
    logic [31:0] word;
    logic        ih;
    logic        dh;
    logic        eq;
    logic [1:0]  pc_code;
    logic [7:0]  ctrl_bits;
    golden_vec_t v;
    ok      = 1'b0;
    line_no = 0;
    fd      = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the golden file %s", GOLDEN_FILE);
    end else begin
      ok = 1'b1;
      while (ok && !$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        line_no++;
        if (line.len() >= 2 && line.substr(0, 1) != "//") begin
          fields = $sscanf(line, "%d %h %b %b %b %d %b",
                           test_id, word, ih, dh, eq, pc_code, ctrl_bits);
          if (fields == 7) begin
            v.test_id  = test_id[7:0];
            v.instr    = word;
            v.ihit     = ih;
            v.dhit     = dh;
            v.mm_equal = eq;
            v.exp_pc   = pc_select_t'(pc_code);
            v.exp_ctrl = ctrl_bits;
            vectors.push_back(v);
          end else begin
            $display("Golden file line %0d is incomplete, it holds %0d of 7 fields",
                     line_no, fields);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (ok && vectors.size() == 0) begin
        $display("The golden file holds no test vectors");
        ok = 1'b0;
      end
    end
  endtask

  initial begin
    bit          ok;
    int          test_lines;
    golden_vec_t v;
    arst_n     <= 1'b0;
    instr      <= '0;
    ihit       <= 1'b0;
    dhit       <= 1'b0;
    mm_equal   <= 1'b0;
    test_lines = 0;
    load_golden(ok);
    if (!ok) begin
      $display("Simulation failed");
      $finish;
    end else begin
      num_vectors    = vectors.size();
      vectors_loaded = 1'b1;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < num_vectors; i++) begin
        v = vectors[i];
        @(posedge clk);
        instr    <= v.instr;
        ihit     <= v.ihit;
        dhit     <= v.dhit;
        mm_equal <= v.mm_equal;
        #(CLK_PERIOD - 1);  // outputs settle well before the next edge
        check_pc_select(pc_select, v.exp_pc, i + 1);
        check_ctrl(ctrl, v.exp_ctrl, i + 1);
        test_lines++;
        if (i == num_vectors - 1 || vectors[i + 1].test_id != v.test_id) begin
          report_test(v.test_id, test_lines);
          test_lines = 0;
        end
      end
      $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // the run needs one cycle per vector plus reset, ten spare cycles cover it
  initial begin
    wait (vectors_loaded);
    #((num_vectors + 10) * CLK_PERIOD);
    $display("Watchdog expired, the run did not end within %0d cycles", num_vectors + 10);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
